//--- flit_fifo.sv
`default_nettype none

module flit_fifo #(
  parameter type item_t = logic,
  parameter int  depth  = 4
) (
  input  logic  BD_in_clk,
  input  logic  rst,
  input  logic  wr_valid,
  input  item_t wr_item,
  output logic  wr_ready,
  output logic  rd_valid,
  output item_t rd_item,
  input  logic  rd_ready
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);

  item_t                mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 do_write;
  logic                 do_read;

  // pointers wrap at depth, which need not be a power of two
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  assign rd_valid = (count != '0);
  // a full buffer still takes a write when the head leaves in the same cycle
  assign wr_ready = (count != cnt_width'(depth)) || rd_ready;
  assign do_write = wr_valid && wr_ready;
  assign do_read  = rd_valid && rd_ready;
  assign rd_item  = mem[rd_ptr];

  always_ff @(posedge BD_in_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_item;
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- input_port.sv
`default_nettype none

module input_port #(
  parameter logic [noc_pkg::dest_width-1:0] node_id = '0
) (
  input  logic                  BD_in_clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  noc_pkg::flit_t        in_flit,
  output logic                  in_ready,
  output logic                  req_valid,
  output noc_pkg::routed_flit_t req_flit,
  input  logic                  req_ready
);

  import noc_pkg::*;

  logic         expect_header;
  out_port_e    held_port;
  out_port_e    flit_port;
  logic         accept;
  routed_flit_t buf_item;

  assign accept = in_valid && in_ready;

  // headers pick the output from the destination id, body flits reuse the held choice
  always_comb begin
    if (!expect_header) begin
      flit_port = held_port;
    end else if (in_flit.payload[dest_width-1:0] == node_id) begin
      flit_port = out_bd;
    end else begin
      flit_port = out_bot;
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (rst) begin
      expect_header <= 1'b1;
      held_port     <= out_bot;
    end else if (accept) begin
      // the flit after a tail opens a new packet
      expect_header <= in_flit.last;
      held_port     <= flit_port;
    end
  end

  // every entry carries its own output, so a packet still queued behind
  // another one for a different output keeps its route
  assign buf_item.port = flit_port;
  assign buf_item.flit = in_flit;

  flit_fifo #(
    .item_t (routed_flit_t),
    .depth  (in_fifo_depth)
  ) u_in_fifo (
    .BD_in_clk (BD_in_clk),
    .rst       (rst),
    .wr_valid  (in_valid),
    .wr_item   (buf_item),
    .wr_ready  (in_ready),
    .rd_valid  (req_valid),
    .rd_item   (req_flit),
    .rd_ready  (req_ready)
  );

endmodule

`default_nettype wire

//--- noc_pkg.sv
`default_nettype none

package noc_pkg;

  // width of the flit payload, the last marker comes on top of it
  localparam int payload_width = 10;

  // the destination node id sits in the low bits of a header payload
  localparam int dest_width = 4;

  // entries in each input buffer
  localparam int in_fifo_depth = 4;

  // entries in each output buffer
  localparam int out_fifo_depth = 2;

  // one link word, bit 10 flags the tail of a packet
  typedef struct packed {
    logic                     last;
    logic [payload_width-1:0] payload;
  } flit_t;

  // outputs of the node, the value doubles as the output index
  typedef enum logic {
    out_bot = 1'b0,
    out_bd  = 1'b1
  } out_port_e;

  // a buffered flit together with the output its packet is headed for
  typedef struct packed {
    out_port_e port;
    flit_t     flit;
  } routed_flit_t;

endpackage

`default_nettype wire

//--- router_node.sv
`default_nettype none

module router_node #(
  parameter logic [noc_pkg::dest_width-1:0] node_id = '0
) (
  input  logic           BD_in_clk,
  input  logic           rst,
  input  logic           top_in_valid,
  input  noc_pkg::flit_t top_in_flit,
  output logic           top_in_ready,
  input  logic           bd_in_valid,
  input  noc_pkg::flit_t bd_in_flit,
  output logic           bd_in_ready,
  output logic           bot_out_valid,
  output noc_pkg::flit_t bot_out_flit,
  input  logic           bot_out_ready,
  output logic           bd_out_valid,
  output noc_pkg::flit_t bd_out_flit,
  input  logic           bd_out_ready
);

  import noc_pkg::*;

  // index 0 carries the top link, index 1 the local board injection
  logic [1:0]         req_valid;
  routed_flit_t [1:0] req_flit;
  logic [1:0]         req_ready;

  input_port #(
    .node_id (node_id)
  ) u_top_port (
    .BD_in_clk (BD_in_clk),
    .rst       (rst),
    .in_valid  (top_in_valid),
    .in_flit   (top_in_flit),
    .in_ready  (top_in_ready),
    .req_valid (req_valid[0]),
    .req_flit  (req_flit[0]),
    .req_ready (req_ready[0])
  );

  input_port #(
    .node_id (node_id)
  ) u_bd_port (
    .BD_in_clk (BD_in_clk),
    .rst       (rst),
    .in_valid  (bd_in_valid),
    .in_flit   (bd_in_flit),
    .in_ready  (bd_in_ready),
    .req_valid (req_valid[1]),
    .req_flit  (req_flit[1]),
    .req_ready (req_ready[1])
  );

  switch_allocator u_switch_allocator (
    .BD_in_clk (BD_in_clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_flit  (req_flit),
    .req_ready (req_ready),
    .bot_valid (bot_out_valid),
    .bot_flit  (bot_out_flit),
    .bot_ready (bot_out_ready),
    .bd_valid  (bd_out_valid),
    .bd_flit   (bd_out_flit),
    .bd_ready  (bd_out_ready)
  );

endmodule

`default_nettype wire

//--- router_node_tb_ref.svh
`ifndef router_node_tb_ref_svh
`define router_node_tb_ref_svh

// expected flits for each source and output, in the order they were sent
flit_t top_to_bot_q [$];
flit_t top_to_bd_q [$];
flit_t bd_to_bot_q [$];
flit_t bd_to_bd_q [$];

// per source packet number for the header tag and sequence number for body flits
int pkt_count [2];
int body_seq [2];

// only a header naming this node stays on the board, everything else heads down the line
function automatic out_port_e expected_port(input flit_t header,
                                            input logic [dest_width-1:0] id);
  out_port_e port;
  if (header.payload[dest_width-1:0] == id) begin
    port = out_bd;
  end else begin
    port = out_bot;
  end
  return port;
endfunction

function automatic int pending(input int src, input int port);
  case (src * 2 + port)
    0:       return top_to_bot_q.size();
    1:       return top_to_bd_q.size();
    2:       return bd_to_bot_q.size();
    3:       return bd_to_bd_q.size();
    default: return 0;
  endcase
endfunction

function automatic int total_pending();
  return pending(0, 0) + pending(0, 1) + pending(1, 0) + pending(1, 1);
endfunction

task automatic push_expected(input int src, input int port, input flit_t f);
  case (src * 2 + port)
    0:       top_to_bot_q.push_back(f);
    1:       top_to_bd_q.push_back(f);
    2:       bd_to_bot_q.push_back(f);
    default: bd_to_bd_q.push_back(f);
  endcase
endtask

task automatic pop_expected(input int src, input int port, output flit_t f, output bit found);
  found = (pending(src, port) != 0);
  f     = '0;
  if (found) begin
    case (src * 2 + port)
      0:       f = top_to_bot_q.pop_front();
      1:       f = top_to_bd_q.pop_front();
      2:       f = bd_to_bot_q.pop_front();
      default: f = bd_to_bd_q.pop_front();
    endcase
  end
endtask

// entered on a falling edge, returns on the falling edge after the handshake
task automatic send_flit(input int src, input flit_t f);
  logic rdy;
  if (src == 0) begin
    top_in_valid = 1'b1;
    top_in_flit  = f;
  end else begin
    bd_in_valid = 1'b1;
    bd_in_flit  = f;
  end
  do begin
    #1;
    rdy = (src == 0) ? top_in_ready : bd_in_ready;
    if (!rdy) begin
      stall_seen = 1'b1;
    end
    @(negedge BD_in_clk);
  end while (!rdy);
  flits_sent++;
endtask

task automatic send_packet(input int src, input int len, input logic [dest_width-1:0] dest);
  flit_t     flits [$];
  flit_t     f;
  out_port_e port;
  int        i;
  // header payload is packet number, source tag, destination id
  f.last    = (len == 1);
  f.payload = {4'(pkt_count[src]), 2'(src), dest};
  port      = expected_port(f, node_id);
  flits.push_back(f);
  for (i = 1; i < len; i++) begin
    f.last    = (i == len - 1);
    f.payload = {1'(src), 9'(body_seq[src])};
    body_seq[src]++;
    flits.push_back(f);
  end
  pkt_count[src]++;
  for (i = 0; i < flits.size(); i++) begin
    push_expected(src, port, flits[i]);
  end
  for (i = 0; i < flits.size(); i++) begin
    send_flit(src, flits[i]);
  end
  if (src == 0) begin
    top_in_valid = 1'b0;
  end else begin
    bd_in_valid = 1'b0;
  end
endtask

// a negative fixed_dest picks a random destination, with the own id favoured
task automatic run_stream(input int src, input int count, input int fixed_dest, input bit gaps);
  int                    len;
  logic [dest_width-1:0] dest;
  repeat (count) begin
    len = 1 + int'($urandom % 4);
    if (fixed_dest >= 0) begin
      dest = dest_width'(fixed_dest);
    end else if ($urandom % 3 == 0) begin
      dest = node_id;
    end else begin
      dest = dest_width'($urandom % 16);
    end
    send_packet(src, len, dest);
    if (gaps) begin
      repeat ($urandom % 3) @(negedge BD_in_clk);
    end
  end
endtask

`endif

//--- router_node_tb.sv
`default_nettype none

module router_node_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import noc_pkg::*;

  localparam logic [dest_width-1:0] node_id = 4'd5;

  logic  BD_in_clk;
  logic  rst;
  logic  top_in_valid;
  flit_t top_in_flit;
  logic  top_in_ready;
  logic  bd_in_valid;
  flit_t bd_in_flit;
  logic  bd_in_ready;
  logic  bot_out_valid;
  flit_t bot_out_flit;
  logic  bot_out_ready;
  logic  bd_out_valid;
  flit_t bd_out_flit;
  logic  bd_out_ready;

  int errors;
  int test_errors;
  int tests_failed;
  int flits_sent;
  int flits_checked;
  bit random_ready;
  bit fair_check;
  bit stall_seen;

  // compare state per output, indexed like out_port_e
  bit    at_header [2];
  bit    held [2];
  flit_t held_flit [2];
  int    cur_src [2];
  int    last_src [2];
  bit    other_waiting [2];

  `include "router_node_tb_ref.svh"

  router_node #(
    .node_id (node_id)
  ) u_router_node (
    .BD_in_clk     (BD_in_clk),
    .rst           (rst),
    .top_in_valid  (top_in_valid),
    .top_in_flit   (top_in_flit),
    .top_in_ready  (top_in_ready),
    .bd_in_valid   (bd_in_valid),
    .bd_in_flit    (bd_in_flit),
    .bd_in_ready   (bd_in_ready),
    .bot_out_valid (bot_out_valid),
    .bot_out_flit  (bot_out_flit),
    .bot_out_ready (bot_out_ready),
    .bd_out_valid  (bd_out_valid),
    .bd_out_flit   (bd_out_flit),
    .bd_out_ready  (bd_out_ready)
  );

  initial begin
    BD_in_clk = 1'b0;
    forever #5 BD_in_clk = ~BD_in_clk;
  end

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      count_error();
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s with %0d errors", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    if (test_errors != 0) begin
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic drain();
    while (total_pending() != 0) begin
      @(negedge BD_in_clk);
    end
    // a few more cycles so that a duplicated flit would still show up
    repeat (6) @(negedge BD_in_clk);
  endtask

  task automatic check_output(input int o, input logic valid, input logic ready, input flit_t f);
    string name;
    flit_t exp_f;
    bit    found;
    int    src;
    name = (o == out_bd) ? "bd_out_flit" : "bot_out_flit";
    if (held[o]) begin
      assert (valid && f === held_flit[o]) else begin
        count_error();
        $display("%s changed or lost valid while ready was low at %0t", name, $time);
      end
    end
    held[o]      = valid && !ready;
    held_flit[o] = f;
    if (valid && ready) begin
      if (at_header[o]) begin
        src = f.payload[5:4];
        if (fair_check) begin
          assert (!(src == last_src[o] && other_waiting[o])) else begin
            count_error();
            $display("source %0d got two packets in a row on %s while the other waited",
                     src, name);
          end
        end
        cur_src[o] = src;
      end
      pop_expected(cur_src[o], o, exp_f, found);
      assert (found) else begin
        count_error();
        $display("unexpected flit %h on %s from source %0d at %0t", f, name, cur_src[o], $time);
      end
      if (found) begin
        assert (f === exp_f) else begin
          count_error();
          $display("error at %0t: %s got %h expected %h", $time, name, f, exp_f);
        end
      end
      flits_checked++;
      at_header[o] = f.last;
      if (f.last) begin
        last_src[o]      = cur_src[o];
        other_waiting[o] = (pending(1 - cur_src[o], o) != 0);
      end
    end
  endtask

  // outputs settle after the rising edge and readies change on the falling edge
  initial begin : compare
    for (int o = 0; o < 2; o++) begin
      at_header[o]     = 1'b1;
      held[o]          = 1'b0;
      cur_src[o]       = 0;
      last_src[o]      = 0;
      other_waiting[o] = 1'b0;
    end
    forever begin
      @(negedge BD_in_clk);
      #2;
      check_output(out_bot, bot_out_valid, bot_out_ready, bot_out_flit);
      check_output(out_bd, bd_out_valid, bd_out_ready, bd_out_flit);
    end
  end

  initial begin : out_ready_drive
    forever begin
      @(negedge BD_in_clk);
      if (random_ready) begin
        bot_out_ready = ($urandom % 10) < 3;
        bd_out_ready  = ($urandom % 10) < 3;
      end else begin
        bot_out_ready = 1'b1;
        bd_out_ready  = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < flits_sent * 20 + 1000) begin
      @(posedge BD_in_clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d flits sent", cycles, flits_sent);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    rst           = 1'b1;
    top_in_valid  = 1'b0;
    top_in_flit   = '0;
    bd_in_valid   = 1'b0;
    bd_in_flit    = '0;
    bot_out_ready = 1'b1;
    bd_out_ready  = 1'b1;
    random_ready  = 1'b0;
    fair_check    = 1'b0;
    stall_seen    = 1'b0;
    errors        = 0;
    test_errors   = 0;
    tests_failed  = 0;
    flits_sent    = 0;
    flits_checked = 0;
    pkt_count[0]  = 0;
    pkt_count[1]  = 0;
    body_seq[0]   = 0;
    body_seq[1]   = 0;
    void'($urandom(32'h71bf));

    repeat (8) begin
      @(negedge BD_in_clk);
      check_bit("bot_out_valid", bot_out_valid, 1'b0);
      check_bit("bd_out_valid", bd_out_valid, 1'b0);
    end
    rst = 1'b0;
    repeat (4) begin
      @(negedge BD_in_clk);
      check_bit("bot_out_valid", bot_out_valid, 1'b0);
      check_bit("bd_out_valid", bd_out_valid, 1'b0);
      check_bit("top_in_ready", top_in_ready, 1'b1);
      check_bit("bd_in_ready", bd_in_ready, 1'b1);
    end
    finish_test("reset");

    fork
      run_stream(0, 16, -1, 1'b1);
      run_stream(1, 16, -1, 1'b1);
    join
    drain();
    finish_test("routing");

    fork
      run_stream(0, 16, -1, 1'b0);
      run_stream(1, 16, -1, 1'b0);
    join
    drain();
    finish_test("packet integrity");

    // both inputs fight for the board output, then for the downstream link
    fair_check = 1'b1;
    fork
      run_stream(0, 20, node_id, 1'b0);
      run_stream(1, 20, node_id, 1'b0);
    join
    drain();
    fork
      run_stream(0, 20, 9, 1'b0);
      run_stream(1, 20, 9, 1'b0);
    join
    drain();
    fair_check = 1'b0;
    finish_test("contention");

    random_ready = 1'b1;
    stall_seen   = 1'b0;
    fork
      run_stream(0, 20, -1, 1'b0);
      run_stream(1, 20, -1, 1'b0);
    join
    random_ready = 1'b0;
    drain();
    assert (stall_seen) else begin
      count_error();
      $display("input ready never dropped while the outputs were held off");
    end
    finish_test("back-pressure");

    $display("tests run 5, tests failed %0d, errors %0d, flits sent %0d, flits checked %0d",
             tests_failed, errors, flits_sent, flits_checked);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
noc_pkg.sv
flit_fifo.sv
input_port.sv
switch_allocator.sv
router_node.sv
router_node_tb.sv

//--- switch_allocator.sv
`default_nettype none

module switch_allocator (
  input  logic                        BD_in_clk,
  input  logic                        rst,
  input  logic [1:0]                  req_valid,
  input  noc_pkg::routed_flit_t [1:0] req_flit,
  output logic [1:0]                  req_ready,
  output logic                        bot_valid,
  output noc_pkg::flit_t              bot_flit,
  input  logic                        bot_ready,
  output logic                        bd_valid,
  output noc_pkg::flit_t              bd_flit,
  input  logic                        bd_ready
);

  import noc_pkg::*;

  // outputs are indexed by out_port_e, inputs by their position in req_valid
  logic [1:0] wants [2];
  logic [1:0] locked;
  logic [1:0] owner;
  logic [1:0] rr_ptr;
  logic [1:0] gnt_valid;
  logic [1:0] gnt_idx;
  logic [1:0] moved;
  flit_t      out_wr_flit [2];
  logic [1:0] out_wr_ready;
  logic [1:0] out_rd_valid;
  flit_t      out_rd_flit [2];
  logic [1:0] out_rd_ready;

  assign out_rd_ready = {bd_ready, bot_ready};

  assign bot_valid = out_rd_valid[out_bot];
  assign bot_flit  = out_rd_flit[out_bot];
  assign bd_valid  = out_rd_valid[out_bd];
  assign bd_flit   = out_rd_flit[out_bd];

  for (genvar o = 0; o < 2; o++) begin : g_out

    for (genvar i = 0; i < 2; i++) begin : g_want
      assign wants[o][i] = req_valid[i] && (req_flit[i].port == out_port_e'(o));
    end

    // a locked output waits for its owner even when the owner's buffer runs dry
    // mid packet, so another packet cannot slip in between two flits
    assign gnt_idx[o] = locked[o] ? owner[o] :
                        (wants[o][rr_ptr[o]] ? rr_ptr[o] : ~rr_ptr[o]);
    assign gnt_valid[o] = locked[o] ? wants[o][owner[o]] : |wants[o];

    assign out_wr_flit[o] = req_flit[gnt_idx[o]].flit;
    assign moved[o]       = gnt_valid[o] && out_wr_ready[o];

    flit_fifo #(
      .item_t (flit_t),
      .depth  (out_fifo_depth)
    ) u_out_fifo (
      .BD_in_clk (BD_in_clk),
      .rst       (rst),
      .wr_valid  (gnt_valid[o]),
      .wr_item   (out_wr_flit[o]),
      .wr_ready  (out_wr_ready[o]),
      .rd_valid  (out_rd_valid[o]),
      .rd_item   (out_rd_flit[o]),
      .rd_ready  (out_rd_ready[o])
    );

  end

  // each input heads for one output at a time, so at most one term is set
  for (genvar i = 0; i < 2; i++) begin : g_ready
    assign req_ready[i] = (moved[out_bot] && (gnt_idx[out_bot] == 1'(i))) ||
                          (moved[out_bd] && (gnt_idx[out_bd] == 1'(i)));
  end

  always_ff @(posedge BD_in_clk) begin
    if (rst) begin
      locked <= '0;
      owner  <= '0;
      rr_ptr <= '0;
    end else begin
      for (int o = 0; o < 2; o++) begin
        if (moved[o]) begin
          if (out_wr_flit[o].last) begin
            // the packet is through, the other input gets first pick next time
            locked[o] <= 1'b0;
            rr_ptr[o] <= ~gnt_idx[o];
          end else begin
            locked[o] <= 1'b1;
            owner[o]  <= gnt_idx[o];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
